// ==== atri_board_pkg.sv ====
package atri_board_pkg;

	////////////////////////////////////////////////////////////
	// Daughterboard geometry
	////////////////////////////////////////////////////////////

	// Daughterboard slots on the carrier
	localparam int NUM_DAUGHTERS = 4;

	// Sense channels per board
	// Order is DDA, TDA, DRSV9, DRSV10
	localparam int NUM_SENSE = 4;

	// TDA power gates trigger channels 0-3
	localparam int SENSE_TDA = 1;
	// DRSV9 power gates trigger channels 4-7
	localparam int SENSE_DRSV9 = 2;

	// Trigger lines from each board
	localparam int TRIG_PER_DB = 8;

	////////////////////////////////////////////////////////////
	// Status types
	////////////////////////////////////////////////////////////

	// One bit per sense channel
	typedef logic [NUM_SENSE-1:0] sense_vec_t;

	// Channel s keeps power at bit 2s+1 and present at bit 2s
	typedef logic [2*NUM_SENSE-1:0] db_status_t;

endpackage

// ==== atri_trig_pkg.sv ====
package atri_trig_pkg;

	////////////////////////////////////////////////////////////
	// Level-4 sources
	////////////////////////////////////////////////////////////

	localparam int NUM_L4 = 5;

	// Source index in every level-4 vector
	localparam int L4_RF0   = 0;
	localparam int L4_RF1   = 1;
	localparam int L4_SOFT  = 2;
	localparam int L4_TIMED = 3;
	localparam int L4_EXT   = 4;

	// Address width for the info readout
	localparam int NL4_BITS = 3;

	// Readout word width
	localparam int INFO_BITS = 32;

	// Entries per info FIFO
	localparam int INFO_DEPTH = 4;

	// External trigger dead time in microsecond ticks
	localparam int EXT_HOLDOFF_TICKS = 3;

	////////////////////////////////////////////////////////////
	// Record types
	////////////////////////////////////////////////////////////

	typedef logic [NUM_L4-1:0] l4_vec_t;
	// Byte d is daughter d, bit c of it is channel c
	typedef logic [3:0][7:0] rf_info_t;
	typedef logic [7:0] soft_info_t;

endpackage

// ==== db_status_tracker.sv ====
`timescale 1ns/1ps

module db_status_tracker import atri_board_pkg::*; (
	input  logic                           irs_clk_i,
	input  logic                           rst_n_i,
	// Per-board sense results
	input  sense_vec_t [NUM_DAUGHTERS-1:0] power_i,
	input  sense_vec_t [NUM_DAUGHTERS-1:0] present_i,
	input  sense_vec_t [NUM_DAUGHTERS-1:0] update_i,
	// Host has seen the change
	input  logic                           ack_i,
	output db_status_t [NUM_DAUGHTERS-1:0] status_o,
	output logic                           status_change_o
);

	db_status_t [NUM_DAUGHTERS-1:0] status_d;
	logic any_update;

	// Interleave power and present per sense channel
	always_comb begin
		for (int d = 0; d < NUM_DAUGHTERS; d++) begin
			for (int s = 0; s < NUM_SENSE; s++) begin
				status_d[d][2*s+1] = power_i[d][s];
				status_d[d][2*s]   = present_i[d][s];
			end
		end
	end

	// Update from any channel of any board
	assign any_update = |update_i;

	////////////////////////////////////////////////////////////
	// Status bytes and change flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge irs_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			status_o        <= '0;
			status_change_o <= 1'b0;
		end else begin
			status_o <= status_d;
			// A fresh update beats the acknowledge
			if (any_update) begin
				status_change_o <= 1'b1;
			end else if (ack_i) begin
				status_change_o <= 1'b0;
			end
		end
	end

	// Host only acknowledges a pending change
	a_ack_needs_flag: assert property (
		@(posedge irs_clk_i) disable iff (!rst_n_i)
		ack_i |-> status_change_o
	);

endmodule

// ==== ext_trig_conditioner.sv ====
`timescale 1ns/1ps

module ext_trig_conditioner import atri_trig_pkg::*; (
	input  logic irs_clk_i,
	input  logic rst_n_i,
	// Asynchronous external trigger
	input  logic trig_i,
	// One-cycle microsecond tick
	input  logic micro_ce_i,
	output logic trig_o
);

	typedef logic [$clog2(EXT_HOLDOFF_TICKS+1)-1:0] hold_cnt_t;

	logic [1:0] sync_q;
	logic level_q;
	logic edge_q;
	hold_cnt_t holdoff_cnt;
	logic holdoff_active;

	assign holdoff_active = (holdoff_cnt != '0);

	////////////////////////////////////////////////////////////
	// Synchronizer and edge detect
	////////////////////////////////////////////////////////////

	always_ff @(posedge irs_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q  <= '0;
			level_q <= 1'b0;
			edge_q  <= 1'b0;
		end else begin
			sync_q  <= {sync_q[0], trig_i};
			level_q <= sync_q[1];
			// Rising edge of the synchronized level
			edge_q  <= sync_q[1] & ~level_q;
		end
	end

	// Holdoff window
	// Loaded on an accepted edge, counts down on ticks
	always_ff @(posedge irs_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			trig_o      <= 1'b0;
			holdoff_cnt <= '0;
		end else begin
			trig_o <= edge_q & ~holdoff_active;
			if (edge_q && !holdoff_active) begin
				holdoff_cnt <= hold_cnt_t'(EXT_HOLDOFF_TICKS);
			end else if (micro_ce_i && holdoff_active) begin
				holdoff_cnt <= holdoff_cnt - hold_cnt_t'(1);
			end
		end
	end

	// Output is always a single-cycle pulse
	a_single_pulse: assert property (
		@(posedge irs_clk_i) disable iff (!rst_n_i)
		trig_o |=> !trig_o
	);

endmodule

// ==== l4_trigger_gen.sv ====
`timescale 1ns/1ps

module l4_trigger_gen import atri_board_pkg::*, atri_trig_pkg::*; (
	input  logic                                      irs_clk_i,
	input  logic                                      rst_n_i,
	// Single-ended trigger lines, one byte per board
	input  logic [NUM_DAUGHTERS-1:0][TRIG_PER_DB-1:0] trg_i,
	input  sense_vec_t [NUM_DAUGHTERS-1:0]            power_i,
	input  logic                                      soft_i,
	input  logic                                      timed_i,
	// Conditioned external pulse
	input  logic                                      ext_i,
	input  logic                                      sampling_i,
	input  logic                                      readout_ready_i,
	output l4_vec_t                                   l4_new_o,
	output logic                                      t1_o,
	output rf_info_t                                  rf_info_o
);

	rf_info_t power_mask;
	rf_info_t trg_masked;
	rf_info_t trg_rise;
	logic rf0_rise;
	logic rf1_rise;

	// Stage 1
	rf_info_t trg_s1;
	logic soft_s1;
	logic timed_s1;

	// Stage 2
	rf_info_t trg_s2;
	logic rf0_s2;
	logic rf1_s2;
	logic soft_s2;
	logic timed_s2;

	l4_vec_t l4_next;

	////////////////////////////////////////////////////////////
	// Power masking and edge detect
	////////////////////////////////////////////////////////////

	// Low half follows TDA power, high half follows DRSV9
	always_comb begin
		for (int d = 0; d < NUM_DAUGHTERS; d++) begin
			for (int c = 0; c < TRIG_PER_DB; c++) begin
				if (c < TRIG_PER_DB/2) begin
					power_mask[d][c] = power_i[d][SENSE_TDA];
				end else begin
					power_mask[d][c] = power_i[d][SENSE_DRSV9];
				end
			end
		end
	end

	assign trg_masked = trg_i & power_mask;

	// New high bits against the previous pattern
	assign trg_rise = trg_s1 & ~trg_s2;

	always_comb begin
		rf0_rise = 1'b0;
		rf1_rise = 1'b0;
		for (int d = 0; d < NUM_DAUGHTERS; d++) begin
			for (int c = 0; c < TRIG_PER_DB; c++) begin
				if (c < TRIG_PER_DB/2) begin
					rf0_rise = rf0_rise | trg_rise[d][c];
				end else begin
					rf1_rise = rf1_rise | trg_rise[d][c];
				end
			end
		end
	end

	// Soft and timed ride the same two stages as the RF path
	always_ff @(posedge irs_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			trg_s1   <= '0;
			soft_s1  <= 1'b0;
			timed_s1 <= 1'b0;
			trg_s2   <= '0;
			rf0_s2   <= 1'b0;
			rf1_s2   <= 1'b0;
			soft_s2  <= 1'b0;
			timed_s2 <= 1'b0;
		end else begin
			trg_s1   <= trg_masked;
			soft_s1  <= soft_i;
			timed_s1 <= timed_i;
			trg_s2   <= trg_s1;
			rf0_s2   <= rf0_rise;
			rf1_s2   <= rf1_rise;
			soft_s2  <= soft_s1;
			timed_s2 <= timed_s1;
		end
	end

	////////////////////////////////////////////////////////////
	// Level-4 flags and T1
	////////////////////////////////////////////////////////////

	always_comb begin
		l4_next           = '0;
		l4_next[L4_RF0]   = rf0_s2;
		l4_next[L4_RF1]   = rf1_s2;
		l4_next[L4_SOFT]  = soft_s2;
		l4_next[L4_TIMED] = timed_s2;
		// External pulse is already late, so it joins here
		l4_next[L4_EXT]   = ext_i;
		if (!sampling_i) begin
			l4_next = '0;
		end
	end

	always_ff @(posedge irs_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			l4_new_o <= '0;
			t1_o     <= 1'b0;
		end else begin
			l4_new_o <= l4_next;
			t1_o     <= (|l4_next) & readout_ready_i;
		end
	end

	// Pattern that goes with the RF flags
	always_ff @(posedge irs_clk_i) begin
		rf_info_o <= trg_s2;
	end

endmodule

// ==== l4_info_fifo.sv ====
`timescale 1ns/1ps

module l4_info_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     irs_clk_i,
	input  logic     rst_n_i,
	input  logic     push_i,
	input  payload_t data_i,
	input  logic     pop_i,
	// Head entry, valid while avail_o is high
	output payload_t data_o,
	output logic     avail_o,
	// Sticky, a record was dropped
	output logic     overflow_o
);

	typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	payload_t mem [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic full;
	logic do_push;
	logic do_pop;

	// Circular pointer step
	function automatic ptr_t ptr_next(input ptr_t ptr);
		if (ptr == ptr_t'(DEPTH-1)) begin
			return '0;
		end
		return ptr + ptr_t'(1);
	endfunction

	assign full    = (count == cnt_t'(DEPTH));
	assign avail_o = (count != '0);
	// Full drops the new record
	assign do_push = push_i & ~full;
	assign do_pop  = pop_i & avail_o;

	always_ff @(posedge irs_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + cnt_t'(1);
			end else if (do_pop && !do_push) begin
				count <= count - cnt_t'(1);
			end
			if (push_i && full) begin
				overflow_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge irs_clk_i) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	// First word falls through
	assign data_o = mem[rd_ptr];

	a_count_bound: assert property (
		@(posedge irs_clk_i) disable iff (!rst_n_i)
		count <= cnt_t'(DEPTH)
	);

endmodule

// ==== trig_info_readout.sv ====
`timescale 1ns/1ps

module trig_info_readout import atri_trig_pkg::*; (
	input  logic                 irs_clk_i,
	input  logic                 rst_n_i,
	input  l4_vec_t              l4_new_i,
	input  rf_info_t             rf_info_i,
	input  soft_info_t           soft_info_i,
	input  logic [NL4_BITS-1:0]  addr_i,
	input  logic                 rd_i,
	output logic [INFO_BITS-1:0] info_o,
	// Bit order rf0, rf1, soft
	output logic [L4_SOFT:0]     avail_o,
	output logic [L4_SOFT:0]     overflow_o
);

	// Soft info delayed to meet its level-4 flag
	soft_info_t soft_info_s1;
	soft_info_t soft_info_s2;
	soft_info_t soft_info_s3;

	rf_info_t rf0_head;
	rf_info_t rf1_head;
	soft_info_t soft_head;
	logic [L4_SOFT:0] sel;
	logic [L4_SOFT:0] pop;

	always_ff @(posedge irs_clk_i) begin
		soft_info_s1 <= soft_info_i;
		soft_info_s2 <= soft_info_s1;
		soft_info_s3 <= soft_info_s2;
	end

	// One-hot FIFO select, addresses past soft select nothing
	always_comb begin
		for (int i = 0; i <= L4_SOFT; i++) begin
			sel[i] = (addr_i == NL4_BITS'(i));
		end
	end

	assign pop = rd_i ? sel : '0;

	////////////////////////////////////////////////////////////
	// Info FIFOs
	////////////////////////////////////////////////////////////

	l4_info_fifo #(.payload_t(rf_info_t), .DEPTH(INFO_DEPTH)) u_rf0_fifo (
		.irs_clk_i  (irs_clk_i),
		.rst_n_i    (rst_n_i),
		.push_i     (l4_new_i[L4_RF0]),
		.data_i     (rf_info_i),
		.pop_i      (pop[L4_RF0]),
		.data_o     (rf0_head),
		.avail_o    (avail_o[L4_RF0]),
		.overflow_o (overflow_o[L4_RF0])
	);

	l4_info_fifo #(.payload_t(rf_info_t), .DEPTH(INFO_DEPTH)) u_rf1_fifo (
		.irs_clk_i  (irs_clk_i),
		.rst_n_i    (rst_n_i),
		.push_i     (l4_new_i[L4_RF1]),
		.data_i     (rf_info_i),
		.pop_i      (pop[L4_RF1]),
		.data_o     (rf1_head),
		.avail_o    (avail_o[L4_RF1]),
		.overflow_o (overflow_o[L4_RF1])
	);

	l4_info_fifo #(.payload_t(soft_info_t), .DEPTH(INFO_DEPTH)) u_soft_fifo (
		.irs_clk_i  (irs_clk_i),
		.rst_n_i    (rst_n_i),
		.push_i     (l4_new_i[L4_SOFT]),
		.data_i     (soft_info_s3),
		.pop_i      (pop[L4_SOFT]),
		.data_o     (soft_head),
		.avail_o    (avail_o[L4_SOFT]),
		.overflow_o (overflow_o[L4_SOFT])
	);

	// Empty or unused address reads back zero
	always_comb begin
		info_o = '0;
		if (sel[L4_RF0] && avail_o[L4_RF0]) begin
			info_o = INFO_BITS'(rf0_head);
		end else if (sel[L4_RF1] && avail_o[L4_RF1]) begin
			info_o = INFO_BITS'(rf1_head);
		end else if (sel[L4_SOFT] && avail_o[L4_SOFT]) begin
			// Soft record is zero-extended
			info_o = INFO_BITS'(soft_head);
		end
	end

	a_read_has_data: assert property (
		@(posedge irs_clk_i) disable iff (!rst_n_i)
		rd_i |-> (|(sel & avail_o))
	) else $warning("info read from empty FIFO or bad address %0d", addr_i);

endmodule

// ==== atri_trig_core.sv ====
`timescale 1ns/1ps

module atri_trig_core import atri_board_pkg::*, atri_trig_pkg::*; (
	input  logic                                      irs_clk_i,
	input  logic                                      rst_n_i,
	// Daughterboard sense
	input  sense_vec_t [NUM_DAUGHTERS-1:0]            db_power_i,
	input  sense_vec_t [NUM_DAUGHTERS-1:0]            db_present_i,
	input  sense_vec_t [NUM_DAUGHTERS-1:0]            db_update_i,
	input  logic                                      status_ack_i,
	// Trigger inputs
	input  logic [NUM_DAUGHTERS-1:0][TRIG_PER_DB-1:0] trg_i,
	input  logic                                      ext_trig_i,
	input  logic                                      micro_ce_i,
	input  logic                                      soft_trig_i,
	input  soft_info_t                                soft_info_i,
	input  logic                                      timed_trig_i,
	// Digitizer state
	input  logic                                      sampling_i,
	input  logic                                      readout_ready_i,
	// Info readout
	input  logic [NL4_BITS-1:0]                       info_addr_i,
	input  logic                                      info_rd_i,
	output db_status_t [NUM_DAUGHTERS-1:0]            status_o,
	output logic                                      status_change_o,
	output logic                                      t1_o,
	output l4_vec_t                                   l4_new_o,
	output logic [INFO_BITS-1:0]                      info_o,
	output logic [L4_SOFT:0]                          info_avail_o,
	output logic [L4_SOFT:0]                          info_overflow_o
);

	// Conditioned external pulse
	logic ext_flag;
	// Masked pattern for the RF FIFOs
	rf_info_t rf_info;

	db_status_tracker u_status (
		.irs_clk_i       (irs_clk_i),
		.rst_n_i         (rst_n_i),
		.power_i         (db_power_i),
		.present_i       (db_present_i),
		.update_i        (db_update_i),
		.ack_i           (status_ack_i),
		.status_o        (status_o),
		.status_change_o (status_change_o)
	);

	ext_trig_conditioner u_ext (
		.irs_clk_i  (irs_clk_i),
		.rst_n_i    (rst_n_i),
		.trig_i     (ext_trig_i),
		.micro_ce_i (micro_ce_i),
		.trig_o     (ext_flag)
	);

	l4_trigger_gen u_l4 (
		.irs_clk_i       (irs_clk_i),
		.rst_n_i         (rst_n_i),
		.trg_i           (trg_i),
		.power_i         (db_power_i),
		.soft_i          (soft_trig_i),
		.timed_i         (timed_trig_i),
		.ext_i           (ext_flag),
		.sampling_i      (sampling_i),
		.readout_ready_i (readout_ready_i),
		.l4_new_o        (l4_new_o),
		.t1_o            (t1_o),
		.rf_info_o       (rf_info)
	);

	trig_info_readout u_info (
		.irs_clk_i   (irs_clk_i),
		.rst_n_i     (rst_n_i),
		.l4_new_i    (l4_new_o),
		.rf_info_i   (rf_info),
		.soft_info_i (soft_info_i),
		.addr_i      (info_addr_i),
		.rd_i        (info_rd_i),
		.info_o      (info_o),
		.avail_o     (info_avail_o),
		.overflow_o  (info_overflow_o)
	);

endmodule

// ==== tb_atri_trig_core.sv ====
`timescale 1ns/1ps

module tb_atri_trig_core import atri_board_pkg::*, atri_trig_pkg::*; ();

	logic irs_clk_i;
	logic rst_n_i;
	sense_vec_t [NUM_DAUGHTERS-1:0] db_power_i;
	sense_vec_t [NUM_DAUGHTERS-1:0] db_present_i;
	sense_vec_t [NUM_DAUGHTERS-1:0] db_update_i;
	logic status_ack_i;
	logic [NUM_DAUGHTERS-1:0][TRIG_PER_DB-1:0] trg_i;
	logic ext_trig_i;
	logic micro_ce_i;
	logic soft_trig_i;
	soft_info_t soft_info_i;
	logic timed_trig_i;
	logic sampling_i;
	logic readout_ready_i;
	logic [NL4_BITS-1:0] info_addr_i;
	logic info_rd_i;
	db_status_t [NUM_DAUGHTERS-1:0] status_o;
	logic status_change_o;
	logic t1_o;
	l4_vec_t l4_new_o;
	logic [INFO_BITS-1:0] info_o;
	logic [L4_SOFT:0] info_avail_o;
	logic [L4_SOFT:0] info_overflow_o;

	// Parsed trace, one entry per command line
	string name_q[$];
	string cmd_q[$];
	logic [31:0] a_q[$];
	logic [31:0] b_q[$];
	logic [31:0] e_q[$];

	int value_errors;
	int other_errors;
	int t1_expected;
	int t1_seen;
	int cycles;
	int cycle_limit;

	atri_trig_core uut (
		.irs_clk_i       (irs_clk_i),
		.rst_n_i         (rst_n_i),
		.db_power_i      (db_power_i),
		.db_present_i    (db_present_i),
		.db_update_i     (db_update_i),
		.status_ack_i    (status_ack_i),
		.trg_i           (trg_i),
		.ext_trig_i      (ext_trig_i),
		.micro_ce_i      (micro_ce_i),
		.soft_trig_i     (soft_trig_i),
		.soft_info_i     (soft_info_i),
		.timed_trig_i    (timed_trig_i),
		.sampling_i      (sampling_i),
		.readout_ready_i (readout_ready_i),
		.info_addr_i     (info_addr_i),
		.info_rd_i       (info_rd_i),
		.status_o        (status_o),
		.status_change_o (status_change_o),
		.t1_o            (t1_o),
		.l4_new_o        (l4_new_o),
		.info_o          (info_o),
		.info_avail_o    (info_avail_o),
		.info_overflow_o (info_overflow_o)
	);

	// 20 ns clock
	always #10 irs_clk_i = ~irs_clk_i;

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_status(input string name, input db_status_t expected,
			input db_status_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_l4(input string name, input l4_vec_t expected, input l4_vec_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [INFO_BITS-1:0] expected,
			input logic [INFO_BITS-1:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// Per-FIFO flag vectors, order rf0, rf1, soft
	task automatic check_flags(input string name, input logic [L4_SOFT:0] expected,
			input logic [L4_SOFT:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			value_errors++;
		end
	endtask

	// Status byte model, pair {power, present} of channel s lands at bits 2s+1:2s
	function automatic db_status_t status_from_sense(input sense_vec_t pwr,
			input sense_vec_t prs);
		db_status_t packed_v;
		packed_v = '0;
		for (int s = 0; s < NUM_SENSE; s++) begin
			packed_v = packed_v | (db_status_t'({pwr[s], prs[s]}) << (2 * s));
		end
		return packed_v;
	endfunction

	////////////////////////////////////////////////////////////
	// Trace reading and command execution
	////////////////////////////////////////////////////////////

	task automatic load_trace();
		int fd;
		int n;
		string line;
		string nm;
		string cm;
		logic [31:0] av;
		logic [31:0] bv;
		logic [31:0] ev;
		fd = $fopen("atri_trig_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open atri_trig_trace.txt, no commands were run");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Skip blank and comment lines
			if (n == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %s %h %h %h", nm, cm, av, bv, ev);
			if (n != 5) begin
				$display("Trace line has a bad format: %s", line);
				other_errors++;
			end else begin
				name_q.push_back(nm);
				cmd_q.push_back(cm);
				a_q.push_back(av);
				b_q.push_back(bv);
				e_q.push_back(ev);
			end
		end
		$fclose(fd);
	endtask

	// Strobe already driven, flags due lat edges after the sampling edge
	task automatic fire(input string name, input int lat, input l4_vec_t expected);
		logic exp_t1;
		// T1 is the OR of the level-4 flags, gated by readout ready
		exp_t1 = (expected != '0) && readout_ready_i;
		@(negedge irs_clk_i);
		trg_i        = '0;
		soft_trig_i  = 1'b0;
		timed_trig_i = 1'b0;
		ext_trig_i   = 1'b0;
		repeat (lat - 1) @(negedge irs_clk_i);
		check_l4({name, "_early"}, '0, l4_new_o);
		@(negedge irs_clk_i);
		check_l4(name, expected, l4_new_o);
		check_bit({name, "_t1"}, exp_t1, t1_o);
		@(negedge irs_clk_i);
		// Flags are single-cycle pulses
		check_l4({name, "_late"}, '0, l4_new_o);
		if (exp_t1) begin
			t1_expected++;
		end
	endtask

	// Called and returns on a falling edge
	task automatic run_line(input string name, input string cmd, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] e);
		int d;
		d = int'(a);
		if (cmd == "pwr" || cmd == "prs") begin
			if (cmd == "pwr") begin
				db_power_i[d] = b[NUM_SENSE-1:0];
			end else begin
				db_present_i[d] = b[NUM_SENSE-1:0];
			end
			@(negedge irs_clk_i);
			// Every board byte follows its own sense inputs
			for (int i = 0; i < NUM_DAUGHTERS; i++) begin
				check_status(name, status_from_sense(db_power_i[i], db_present_i[i]),
					status_o[i]);
			end
		end else if (cmd == "upd" || cmd == "ack") begin
			// Ack line may carry a coincident update on board 0
			if (cmd == "upd") begin
				db_update_i[d] = b[NUM_SENSE-1:0];
			end else begin
				status_ack_i   = 1'b1;
				db_update_i[0] = a[NUM_SENSE-1:0];
			end
			@(negedge irs_clk_i);
			status_ack_i = 1'b0;
			db_update_i  = '0;
			check_bit(name, e[0], status_change_o);
		end else if (cmd == "trg") begin
			trg_i[d] = b[TRIG_PER_DB-1:0];
			fire(name, 2, e[NUM_L4-1:0]);
		end else if (cmd == "soft") begin
			soft_trig_i = 1'b1;
			soft_info_i = b[7:0];
			fire(name, 2, e[NUM_L4-1:0]);
		end else if (cmd == "timed") begin
			timed_trig_i = 1'b1;
			fire(name, 2, e[NUM_L4-1:0]);
		end else if (cmd == "ext") begin
			// Synchronizer, edge detect and holdoff add two edges
			ext_trig_i = 1'b1;
			fire(name, 4, e[NUM_L4-1:0]);
		end else if (cmd == "tick") begin
			repeat (d) begin
				micro_ce_i = 1'b1;
				@(negedge irs_clk_i);
				micro_ce_i = 1'b0;
				@(negedge irs_clk_i);
			end
		end else if (cmd == "cfg") begin
			sampling_i      = a[0];
			readout_ready_i = b[0];
			@(negedge irs_clk_i);
		end else if (cmd == "read") begin
			info_addr_i = a[NL4_BITS-1:0];
			@(negedge irs_clk_i);
			check_word(name, e[INFO_BITS-1:0], info_o);
			// Pop only when the line asks for it
			info_rd_i = b[0];
			@(negedge irs_clk_i);
			info_rd_i = 1'b0;
		end else if (cmd == "flags") begin
			check_flags({name, "_avail"}, a[L4_SOFT:0], info_avail_o);
			check_flags({name, "_overflow"}, e[L4_SOFT:0], info_overflow_o);
		end else begin
			$display("Trace line %s has an unknown command %s", name, cmd);
			other_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////

	// T1 pulses seen mid-cycle
	always @(negedge irs_clk_i) begin
		if (rst_n_i && t1_o === 1'b1) begin
			t1_seen++;
		end
	end

	// Run limit from the trace length
	always @(posedge irs_clk_i) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors: %0d wrong values, %0d other failures",
				value_errors, other_errors);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		irs_clk_i       = 1'b0;
		rst_n_i         = 1'b0;
		db_power_i      = '0;
		db_present_i    = '0;
		db_update_i     = '0;
		status_ack_i    = 1'b0;
		trg_i           = '0;
		ext_trig_i      = 1'b0;
		micro_ce_i      = 1'b0;
		soft_trig_i     = 1'b0;
		soft_info_i     = '0;
		timed_trig_i    = 1'b0;
		sampling_i      = 1'b1;
		readout_ready_i = 1'b1;
		info_addr_i     = '0;
		info_rd_i       = 1'b0;
		value_errors    = 0;
		other_errors    = 0;
		t1_expected     = 0;
		t1_seen         = 0;
		cycles          = 0;
		load_trace();
		cycle_limit = name_q.size() * 16;
		// Reset over four rising edges
		repeat (4) @(posedge irs_clk_i);
		@(negedge irs_clk_i);
		rst_n_i = 1'b1;
		@(negedge irs_clk_i);
		foreach (name_q[i]) begin
			run_line(name_q[i], cmd_q[i], a_q[i], b_q[i], e_q[i]);
		end
		check_count("t1_total", t1_expected, t1_seen);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== atri_trig_trace.txt ====
# name cmd a b e (hex); a board, address, tick count or sampling; b value, info, pop or ready
# e expected status byte, change flag, level-4 flags, info word or overflow bits; flags: a avail
st_pwr0     pwr   0 2  0 8
st_prs0     prs   0 3  0d
st_pwr2     pwr   2 6  28
st_upd1     upd   1 4  1
st_ack1     ack   0 0  0
st_upd3     upd   3 1  1
st_ack_upd  ack   2 0  1
st_ack2     ack   0 0  0
rf0_pwr     trg   0 04 01
rf0_head    read  0 1  00000004
rf0_unpwr   trg   1 04 00
rf1_pwr     trg   2 40 02
rf1_head    read  1 1  00400000
soft_a5     soft  0 a5 04
soft_head   read  2 1  000000a5
timed_a     timed 0 0  08
none_stored flags 0 0  0
no_samp_cfg cfg   0 1  0
no_samp     trg   0 01 00
no_rdy_cfg  cfg   1 0  0
no_rdy      timed 0 0  08
armed_cfg   cfg   1 1  0
ext_first   ext   0 0  10
ext_hold    ext   0 0  00
ext_ticks   tick  3 0  0
ext_again   ext   0 0  10
ovf_1       trg   0 01 01
ovf_2       trg   0 02 01
ovf_3       trg   0 04 01
ovf_4       trg   0 08 01
ovf_5       trg   0 03 01
ovf_full    flags 1 0  1
ovf_rd1     read  0 1  00000001
ovf_rd2     read  0 1  00000002
ovf_rd3     read  0 1  00000004
ovf_rd4     read  0 1  00000008
ovf_empty   read  0 0  00000000
ovf_sticky  flags 0 0  1

// ==== verilog.f ====
atri_board_pkg.sv
atri_trig_pkg.sv
db_status_tracker.sv
ext_trig_conditioner.sv
l4_trigger_gen.sv
l4_info_fifo.sv
trig_info_readout.sv
atri_trig_core.sv
tb_atri_trig_core.sv
